/* issue_pkg.sv */
package issue_pkg;

    // architectural register file
    localparam int reg_addr_width = 5;
    localparam int reg_count      = 32;   // 2**reg_addr_width, r0 hardwired

    // functional unit numbering
    localparam int unit_width = 2;

    localparam logic [unit_width-1:0] unit_alu   = 2'd0;
    localparam logic [unit_width-1:0] unit_shift = 2'd1;
    localparam logic [unit_width-1:0] unit_mul   = 2'd2;
    localparam logic [unit_width-1:0] unit_load  = 2'd3;

    // cycles a destination stays pending after issue, per unit code
    // issue_valid cycle counts as the first one
    localparam int unit_latency [4] = '{
        1,      // alu
        2,      // shift
        3,      // mul
        5       // load
    };

    // one bit per cycle in flight
    // must cover the slowest unit above
    localparam int row_width = 5;

    // front end buffering
    localparam int queue_depth     = 4;
    localparam int queue_ptr_width = $clog2(queue_depth);

endpackage

/* instr_queue.sv */
`timescale 1ns/1ps

module instr_queue
    import issue_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    // strobe from the front end, fields valid only with it
    input  logic                      instr_valid,
    input  logic [unit_width-1:0]     instr_unit,
    input  logic [reg_addr_width-1:0] instr_src_a,
    input  logic [reg_addr_width-1:0] instr_src_b,
    input  logic [reg_addr_width-1:0] instr_dest_a,
    input  logic [reg_addr_width-1:0] instr_dest_b,
    input  logic                      instr_wr_a,
    input  logic                      instr_wr_b,
    input  logic                      pop,            // head issued this cycle
    // oldest entry
    output logic                      head_valid,
    output logic [unit_width-1:0]     head_unit,
    output logic [reg_addr_width-1:0] head_src_a,
    output logic [reg_addr_width-1:0] head_src_b,
    output logic [reg_addr_width-1:0] head_dest_a,
    output logic [reg_addr_width-1:0] head_dest_b,
    output logic                      head_wr_a,
    output logic                      head_wr_b,
    output logic                      queue_overflow  // sticky
);

    logic [queue_ptr_width-1:0] rd_ptr;
    logic [queue_ptr_width-1:0] wr_ptr;
    logic [queue_ptr_width:0]   count;      // 0 .. queue_depth
    logic                       full;
    logic                       push;
    logic                       take;

    // entry storage
    logic [unit_width-1:0]     unit_mem  [queue_depth];
    logic [reg_addr_width-1:0] src_a_mem [queue_depth];
    logic [reg_addr_width-1:0] src_b_mem [queue_depth];
    logic [reg_addr_width-1:0] dst_a_mem [queue_depth];
    logic [reg_addr_width-1:0] dst_b_mem [queue_depth];
    logic                      wr_a_mem  [queue_depth];
    logic                      wr_b_mem  [queue_depth];

    assign full = count[queue_ptr_width];   // depth is a power of two
    assign push = instr_valid & ~full;      // full queue drops, even when popping
    assign take = pop & head_valid;

    assign head_valid  = (count != '0);
    assign head_unit   = unit_mem[rd_ptr];
    assign head_src_a  = src_a_mem[rd_ptr];
    assign head_src_b  = src_b_mem[rd_ptr];
    assign head_dest_a = dst_a_mem[rd_ptr];
    assign head_dest_b = dst_b_mem[rd_ptr];
    assign head_wr_a   = wr_a_mem[rd_ptr];
    assign head_wr_b   = wr_b_mem[rd_ptr];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rd_ptr         <= '0;
            wr_ptr         <= '0;
            count          <= '0;
            queue_overflow <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + queue_ptr_width'(1);
            if (take) rd_ptr <= rd_ptr + queue_ptr_width'(1);
            case ({push, take})
                2'b10:   count <= count + (queue_ptr_width + 1)'(1);
                2'b01:   count <= count - (queue_ptr_width + 1)'(1);
                default: count <= count;    // idle, or push and pop together
            endcase
            if (instr_valid && full) queue_overflow <= 1'b1;    // lost strobe
        end
    end

    // payload write, pointer picks the slot
    always_ff @(posedge clock) begin
        if (push) begin
            unit_mem[wr_ptr]  <= instr_unit;
            src_a_mem[wr_ptr] <= instr_src_a;
            src_b_mem[wr_ptr] <= instr_src_b;
            dst_a_mem[wr_ptr] <= instr_dest_a;
            dst_b_mem[wr_ptr] <= instr_dest_b;
            wr_a_mem[wr_ptr]  <= instr_wr_a;
            wr_b_mem[wr_ptr]  <= instr_wr_b;
        end
    end

endmodule

/* register_scoreboard.sv */
`timescale 1ns/1ps

module register_scoreboard
    import issue_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    // lookup port a, combinational
    input  logic [reg_addr_width-1:0] lookup_addr_a,
    output logic                      lookup_pending_a,
    output logic [unit_width-1:0]     lookup_unit_a,
    output logic [row_width-1:0]      lookup_row_a,
    // lookup port b
    input  logic [reg_addr_width-1:0] lookup_addr_b,
    output logic                      lookup_pending_b,
    output logic [unit_width-1:0]     lookup_unit_b,
    output logic [row_width-1:0]      lookup_row_b,
    output logic [reg_count-1:0]      pending_mask,   // all rows at once
    // claims from issue, shared unit and row
    input  logic [unit_width-1:0]     claim_unit,
    input  logic [row_width-1:0]      claim_row,
    input  logic [reg_addr_width-1:0] claim_addr_a,
    input  logic                      claim_en_a,
    input  logic [reg_addr_width-1:0] claim_addr_b,
    input  logic                      claim_en_b
);

    // per register state
    logic [reg_count-1:0]  pending;
    logic [unit_width-1:0] unit_q [reg_count];  // unit that will write it
    logic [row_width-1:0]  row_q  [reg_count];  // one bit, walks toward bit 0

    logic claim_ok_a;
    logic claim_ok_b;

    // r0 is never written back, so it never goes pending
    assign claim_ok_a = claim_en_a && (claim_addr_a != '0);
    assign claim_ok_b = claim_en_b && (claim_addr_b != '0);

    assign lookup_pending_a = pending[lookup_addr_a];
    assign lookup_unit_a    = unit_q[lookup_addr_a];
    assign lookup_row_a     = row_q[lookup_addr_a];

    assign lookup_pending_b = pending[lookup_addr_b];
    assign lookup_unit_b    = unit_q[lookup_addr_b];
    assign lookup_row_b     = row_q[lookup_addr_b];

    assign pending_mask = pending;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pending <= '0;
            for (int i = 0; i < reg_count; i++) begin
                unit_q[i] <= '0;
                row_q[i]  <= '0;
            end
        end else begin
            // advance every row one stage
            for (int i = 0; i < reg_count; i++) begin
                row_q[i] <= row_q[i] >> 1;
                // bit 0 was the writeback cycle, row now empty
                if (row_q[i][row_width-1:1] == '0) begin
                    pending[i] <= 1'b0;
                    unit_q[i]  <= '0;
                end
            end

            // new claims win over the shift, later assignment takes effect
            if (claim_ok_a) begin
                pending[claim_addr_a] <= 1'b1;
                unit_q[claim_addr_a]  <= claim_unit;
                row_q[claim_addr_a]   <= claim_row;
            end
            // same register on both ports writes identical values
            if (claim_ok_b) begin
                pending[claim_addr_b] <= 1'b1;
                unit_q[claim_addr_b]  <= claim_unit;
                row_q[claim_addr_b]   <= claim_row;
            end
        end
    end

endmodule

/* hazard_issue_control.sv */
`timescale 1ns/1ps

module hazard_issue_control
    import issue_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    // queue head
    input  logic                      head_valid,
    input  logic [unit_width-1:0]     head_unit,
    input  logic [reg_addr_width-1:0] head_src_a,
    input  logic [reg_addr_width-1:0] head_src_b,
    input  logic [reg_addr_width-1:0] head_dest_a,
    input  logic [reg_addr_width-1:0] head_dest_b,
    input  logic                      head_wr_a,
    input  logic                      head_wr_b,
    // scoreboard answers
    input  logic                      lookup_pending_a,
    input  logic                      lookup_pending_b,
    input  logic [reg_count-1:0]      pending_mask,
    // scoreboard questions
    output logic [reg_addr_width-1:0] lookup_addr_a,
    output logic [reg_addr_width-1:0] lookup_addr_b,
    output logic                      pop,           // also the issue strobe
    // claim, doubles as the writeback load
    output logic [unit_width-1:0]     claim_unit,
    output logic [row_width-1:0]      claim_row,
    output logic [reg_addr_width-1:0] claim_addr_a,
    output logic                      claim_en_a,
    output logic [reg_addr_width-1:0] claim_addr_b,
    output logic                      claim_en_b,
    // registered issue record
    output logic                      issue_valid,
    output logic [unit_width-1:0]     issue_unit,
    output logic [reg_addr_width-1:0] issue_dest_a,
    output logic [reg_addr_width-1:0] issue_dest_b,
    output logic                      issue_wr_a,
    output logic                      issue_wr_b
);

    logic [row_width-1:0] resv;         // bit i set, writeback i cycles from now
    logic [row_width-1:0] resv_shift;   // same vector after this edge
    logic [row_width-1:0] slot_row;     // one-hot, bit L-1
    logic                 raw_hazard;
    logic                 waw_hazard;
    logic                 slot_hazard;
    logic                 issue_fire;

    assign lookup_addr_a = head_src_a;
    assign lookup_addr_b = head_src_b;

    // latency to one-hot row, bit L-1
    always_comb begin
        slot_row = '0;
        case (head_unit)
            unit_alu:   slot_row = row_width'(1) << (unit_latency[unit_alu] - 1);
            unit_shift: slot_row = row_width'(1) << (unit_latency[unit_shift] - 1);
            unit_mul:   slot_row = row_width'(1) << (unit_latency[unit_mul] - 1);
            unit_load:  slot_row = row_width'(1) << (unit_latency[unit_load] - 1);
        endcase
    end

    assign resv_shift = resv >> 1;

    // source still waiting on a writeback
    assign raw_hazard = lookup_pending_a | lookup_pending_b;

    // older write to the same destination not done yet
    assign waw_hazard = (head_wr_a & pending_mask[head_dest_a])
                      | (head_wr_b & pending_mask[head_dest_b]);

    // one writeback per cycle, slot taken by an older, slower instruction
    assign slot_hazard = |(resv_shift & slot_row);

    assign issue_fire = head_valid & ~raw_hazard & ~waw_hazard & ~slot_hazard;
    assign pop        = issue_fire;

    assign claim_unit   = head_unit;
    assign claim_row    = slot_row;
    assign claim_addr_a = head_dest_a;
    assign claim_addr_b = head_dest_b;
    assign claim_en_a   = issue_fire & head_wr_a;   // r0 filtered in the scoreboard
    assign claim_en_b   = issue_fire & head_wr_b;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            resv        <= '0;
            issue_valid <= 1'b0;
        end else begin
            resv        <= resv_shift | (issue_fire ? slot_row : '0);
            issue_valid <= issue_fire;
        end
    end

    // issue record, only meaningful with issue_valid
    always_ff @(posedge clock) begin
        if (issue_fire) begin
            issue_unit   <= head_unit;
            issue_dest_a <= head_dest_a;
            issue_dest_b <= head_dest_b;
            issue_wr_a   <= head_wr_a;
            issue_wr_b   <= head_wr_b;
        end
    end

endmodule

/* writeback_sequencer.sv */
`timescale 1ns/1ps

module writeback_sequencer
    import issue_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    // record of the instruction issuing now
    input  logic                      load,
    input  logic [row_width-1:0]      load_slot,    // one-hot, bit L-1
    input  logic [unit_width-1:0]     load_unit,
    input  logic [reg_addr_width-1:0] load_dest_a,
    input  logic [reg_addr_width-1:0] load_dest_b,
    input  logic                      load_wr_a,
    input  logic                      load_wr_b,
    // completion, straight from slot 0
    output logic                      wb_valid,
    output logic [unit_width-1:0]     wb_unit,
    output logic [reg_addr_width-1:0] wb_dest_a,
    output logic [reg_addr_width-1:0] wb_dest_b,
    output logic                      wb_wr_a,
    output logic                      wb_wr_b
);

    // slot i leaves as a writeback i edges from now
    logic [row_width-1:0]      slot_valid;
    logic [unit_width-1:0]     slot_unit  [row_width];
    logic [reg_addr_width-1:0] slot_dst_a [row_width];
    logic [reg_addr_width-1:0] slot_dst_b [row_width];
    logic                      slot_wr_a  [row_width];
    logic                      slot_wr_b  [row_width];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            slot_valid <= '0;
        end else begin
            // issue control keeps the loaded slot free after the shift
            slot_valid <= (slot_valid >> 1) | (load ? load_slot : '0);
        end
    end

    always_ff @(posedge clock) begin
        // move down one slot, top slot just goes stale
        for (int i = 0; i < row_width - 1; i++) begin
            slot_unit[i]  <= slot_unit[i+1];
            slot_dst_a[i] <= slot_dst_a[i+1];
            slot_dst_b[i] <= slot_dst_b[i+1];
            slot_wr_a[i]  <= slot_wr_a[i+1];
            slot_wr_b[i]  <= slot_wr_b[i+1];
        end
        // load overrides the shift into its slot
        for (int i = 0; i < row_width; i++) begin
            if (load && load_slot[i]) begin
                slot_unit[i]  <= load_unit;
                slot_dst_a[i] <= load_dest_a;
                slot_dst_b[i] <= load_dest_b;
                slot_wr_a[i]  <= load_wr_a;
                slot_wr_b[i]  <= load_wr_b;
            end
        end
    end

    assign wb_valid  = slot_valid[0];
    assign wb_unit   = slot_unit[0];
    assign wb_dest_a = slot_dst_a[0];
    assign wb_dest_b = slot_dst_b[0];
    assign wb_wr_a   = slot_wr_a[0];     // raw enables, r0 included
    assign wb_wr_b   = slot_wr_b[0];

endmodule

/* issue_unit_top.sv */
`timescale 1ns/1ps

module issue_unit_top
    import issue_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    // instruction strobe in
    input  logic                      instr_valid,
    input  logic [unit_width-1:0]     instr_unit,
    input  logic [reg_addr_width-1:0] instr_src_a,
    input  logic [reg_addr_width-1:0] instr_src_b,
    input  logic [reg_addr_width-1:0] instr_dest_a,
    input  logic [reg_addr_width-1:0] instr_dest_b,
    input  logic                      instr_wr_a,
    input  logic                      instr_wr_b,
    // issue side
    output logic                      issue_valid,
    output logic [unit_width-1:0]     issue_unit,
    output logic [reg_addr_width-1:0] issue_dest_a,
    output logic [reg_addr_width-1:0] issue_dest_b,
    output logic                      issue_wr_a,
    output logic                      issue_wr_b,
    // completion side
    output logic                      wb_valid,
    output logic [unit_width-1:0]     wb_unit,
    output logic [reg_addr_width-1:0] wb_dest_a,
    output logic [reg_addr_width-1:0] wb_dest_b,
    output logic                      wb_wr_a,
    output logic                      wb_wr_b,
    output logic                      queue_overflow
);

    // queue head to control
    logic                      head_valid;
    logic [unit_width-1:0]     head_unit;
    logic [reg_addr_width-1:0] head_src_a;
    logic [reg_addr_width-1:0] head_src_b;
    logic [reg_addr_width-1:0] head_dest_a;
    logic [reg_addr_width-1:0] head_dest_b;
    logic                      head_wr_a;
    logic                      head_wr_b;
    logic                      pop;

    // control and scoreboard
    logic [reg_addr_width-1:0] lookup_addr_a;
    logic [reg_addr_width-1:0] lookup_addr_b;
    logic                      lookup_pending_a;
    logic                      lookup_pending_b;
    logic [reg_count-1:0]      pending_mask;
    logic [unit_width-1:0]     claim_unit;
    logic [row_width-1:0]      claim_row;
    logic [reg_addr_width-1:0] claim_addr_a;
    logic [reg_addr_width-1:0] claim_addr_b;
    logic                      claim_en_a;
    logic                      claim_en_b;

    instr_queue u_queue (.*);

    hazard_issue_control u_control (.*);

    register_scoreboard u_scoreboard (
        .lookup_unit_a (),  // control needs only the pending bits
        .lookup_row_a  (),
        .lookup_unit_b (),
        .lookup_row_b  (),
        .*
    );

    // claim lines carry the record into its writeback slot
    writeback_sequencer u_writeback (
        .clock       (clock),
        .reset       (reset),
        .load        (pop),
        .load_slot   (claim_row),
        .load_unit   (claim_unit),
        .load_dest_a (claim_addr_a),
        .load_dest_b (claim_addr_b),
        .load_wr_a   (claim_en_a),
        .load_wr_b   (claim_en_b),
        .wb_valid    (wb_valid),
        .wb_unit     (wb_unit),
        .wb_dest_a   (wb_dest_a),
        .wb_dest_b   (wb_dest_b),
        .wb_wr_a     (wb_wr_a),
        .wb_wr_b     (wb_wr_b)
    );

endmodule

/* issue_unit_chk.sv */
`timescale 1ns/1ps

module issue_unit_chk
    import issue_pkg::*;
(
    input logic                      clock,
    input logic                      reset,
    input logic                      instr_valid,
    input logic [unit_width-1:0]     instr_unit,
    input logic [reg_addr_width-1:0] instr_src_a,
    input logic [reg_addr_width-1:0] instr_src_b,
    input logic [reg_addr_width-1:0] instr_dest_a,
    input logic [reg_addr_width-1:0] instr_dest_b,
    input logic                      instr_wr_a,
    input logic                      instr_wr_b,
    input logic                      issue_valid,
    input logic [unit_width-1:0]     issue_unit,
    input logic [reg_addr_width-1:0] issue_dest_a,
    input logic [reg_addr_width-1:0] issue_dest_b,
    input logic                      issue_wr_a,
    input logic                      issue_wr_b,
    input logic                      wb_valid,
    input logic [unit_width-1:0]     wb_unit,
    input logic [reg_addr_width-1:0] wb_dest_a,
    input logic [reg_addr_width-1:0] wb_dest_b,
    input logic                      wb_wr_a,
    input logic                      wb_wr_b,
    input logic                      queue_overflow,
    input logic [reg_count-1:0]      pending_mask    // scoreboard rows, only r0 watched
);

    typedef logic [unit_width+2*reg_addr_width+1:0] rec_t;  // unit, dest_a, dest_b, wr_a, wr_b
    typedef logic [2*reg_addr_width-1:0]            src_t;  // src_a, src_b

    int error_count = 0;
    int accepted_count;

    // shadow queue, accepted but not yet seen on issue_valid
    rec_t       sq_rec [8];
    src_t       sq_src [8];
    logic [2:0] sq_head;
    logic [2:0] sq_tail;
    logic [3:0] sq_count;
    logic       model_full;
    logic       accept;
    logic       ovf_model;

    // shadow pending table, fed by the issue and wb strobes
    logic [reg_count-1:0] shadow_pend;
    logic [reg_count-1:0] claim_now;
    logic [reg_count-1:0] release_now;
    logic [reg_count-1:0] busy_q;       // what the issue decision one cycle back saw
    src_t                 head_src;
    logic                 hazard;

    // expected writebacks, ring indexed by due cycle
    rec_t       due_rec [8];
    logic [7:0] due_valid;
    logic [2:0] cyc;
    logic [2:0] due_slot;
    int         issue_lat;
    logic       now_wb;                 // latency 1, completes in its issue cycle
    rec_t       issue_rec;
    rec_t       wb_rec;
    rec_t       exp_wb_rec;
    logic       exp_wb_valid;

    // real queue count lags by the pop that issue_valid reports now
    assign model_full = (sq_count - 4'(issue_valid)) == 4'(queue_depth);
    assign accept     = instr_valid & ~model_full;

    assign issue_rec = {issue_unit, issue_dest_a, issue_dest_b, issue_wr_a, issue_wr_b};
    assign wb_rec    = {wb_unit, wb_dest_a, wb_dest_b, wb_wr_a, wb_wr_b};
    assign issue_lat = unit_latency[issue_unit];
    assign due_slot  = cyc + 3'(issue_lat - 1);
    assign now_wb    = issue_valid && (issue_lat == 1);

    assign exp_wb_valid = due_valid[cyc] | now_wb;
    assign exp_wb_rec   = now_wb ? issue_rec : due_rec[cyc];

    always_comb begin
        claim_now   = '0;
        release_now = '0;
        if (issue_valid && issue_wr_a) claim_now[issue_dest_a] = 1'b1;
        if (issue_valid && issue_wr_b) claim_now[issue_dest_b] = 1'b1;
        if (wb_valid && wb_wr_a) release_now[wb_dest_a] = 1'b1;
        if (wb_valid && wb_wr_b) release_now[wb_dest_b] = 1'b1;
        claim_now[0]   = 1'b0;      // r0 never waits
        release_now[0] = 1'b0;
    end

    assign head_src = sq_src[sq_head];
    assign hazard   = busy_q[head_src[2*reg_addr_width-1:reg_addr_width]]
                    | busy_q[head_src[reg_addr_width-1:0]]
                    | (issue_wr_a & busy_q[issue_dest_a])
                    | (issue_wr_b & busy_q[issue_dest_b]);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            sq_head        <= '0;
            sq_tail        <= '0;
            sq_count       <= '0;
            ovf_model      <= 1'b0;
            accepted_count <= 0;
            shadow_pend    <= '0;
            busy_q         <= '0;
            cyc            <= '0;
            due_valid      <= '0;
        end else begin
            if (accept) begin
                sq_tail        <= sq_tail + 3'd1;
                accepted_count <= accepted_count + 1;
            end
            if (issue_valid && sq_count != '0) sq_head <= sq_head + 3'd1;
            sq_count <= sq_count + 4'(accept) - 4'(issue_valid && sq_count != '0);
            if (instr_valid && model_full) ovf_model <= 1'b1;   // dropped strobe
            shadow_pend <= (shadow_pend | claim_now) & ~release_now;
            busy_q      <= shadow_pend | claim_now;
            cyc                <= cyc + 3'd1;
            due_valid[cyc]     <= 1'b0;                      // consumed this cycle
            if (issue_valid && issue_lat > 1) due_valid[due_slot] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            sq_rec[sq_tail] <= {instr_unit, instr_dest_a, instr_dest_b, instr_wr_a, instr_wr_b};
            sq_src[sq_tail] <= {instr_src_a, instr_src_b};
        end
        if (issue_valid && issue_lat > 1) due_rec[due_slot] <= issue_rec;
    end

    a_overflow: assert property (@(posedge clock) disable iff (!reset)
        queue_overflow == ovf_model)
        else begin
            error_count++;
            $error("Mismatch queue_overflow: got 0x%0h expected 0x%0h",
                   $sampled(queue_overflow), $sampled(ovf_model));
        end

    a_issue_known: assert property (@(posedge clock) disable iff (!reset)
        issue_valid |-> sq_count != '0)
        else begin
            error_count++;
            $error("issue_valid seen with no accepted instruction waiting");
        end

    a_issue_order: assert property (@(posedge clock) disable iff (!reset)
        issue_valid |-> issue_rec == sq_rec[sq_head])
        else begin
            error_count++;
            $error("Mismatch issue record: got 0x%0h expected 0x%0h",
                   $sampled(issue_rec), $sampled(sq_rec[sq_head]));
        end

    a_no_hazard: assert property (@(posedge clock) disable iff (!reset)
        issue_valid |-> !hazard)
        else begin
            error_count++;
            $error("instruction issued while a source or destination was still pending");
        end

    a_wb_valid: assert property (@(posedge clock) disable iff (!reset)
        wb_valid == exp_wb_valid)
        else begin
            error_count++;
            $error("Mismatch wb_valid: got 0x%0h expected 0x%0h",
                   $sampled(wb_valid), $sampled(exp_wb_valid));
        end

    a_wb_record: assert property (@(posedge clock) disable iff (!reset)
        wb_valid |-> wb_rec == exp_wb_rec)
        else begin
            error_count++;
            $error("Mismatch wb record: got 0x%0h expected 0x%0h",
                   $sampled(wb_rec), $sampled(exp_wb_rec));
        end

    a_one_wb: assert property (@(posedge clock) disable iff (!reset)
        issue_valid |-> !due_valid[due_slot])
        else begin
            error_count++;
            $error("two writebacks fall due in the same cycle");
        end

    a_r0_free: assert property (@(posedge clock) disable iff (!reset)
        !pending_mask[0])
        else begin
            error_count++;
            $error("register 0 went pending in the scoreboard");
        end

endmodule

/* tb_issue_unit.sv */
`timescale 1ns/1ps

module tb_issue_unit
    import issue_pkg::*;
();

    logic                      clock;
    logic                      reset;
    logic                      instr_valid;
    logic [unit_width-1:0]     instr_unit;
    logic [reg_addr_width-1:0] instr_src_a;
    logic [reg_addr_width-1:0] instr_src_b;
    logic [reg_addr_width-1:0] instr_dest_a;
    logic [reg_addr_width-1:0] instr_dest_b;
    logic                      instr_wr_a;
    logic                      instr_wr_b;
    logic                      issue_valid;
    logic [unit_width-1:0]     issue_unit;
    logic [reg_addr_width-1:0] issue_dest_a;
    logic [reg_addr_width-1:0] issue_dest_b;
    logic                      issue_wr_a;
    logic                      issue_wr_b;
    logic                      wb_valid;
    logic [unit_width-1:0]     wb_unit;
    logic [reg_addr_width-1:0] wb_dest_a;
    logic [reg_addr_width-1:0] wb_dest_b;
    logic                      wb_wr_a;
    logic                      wb_wr_b;
    logic                      queue_overflow;

    int seed          = 32'hb2ca22ac;
    int random_cycles = 200;    // mixed phase with bursts
    int spaced_count  = 20;     // one instruction, then idle until drained
    int tb_errors     = 0;
    int issued_count  = 0;
    int watchdog_cycles;
    bit drained;

    issue_unit_top dut (.*);

    bind issue_unit_top issue_unit_chk u_chk (.*);

    always #50 clock = ~clock;

    // issue strobes counted mid cycle where issue_valid is stable
    always @(negedge clock) begin
        if (reset && issue_valid) issued_count <= issued_count + 1;
    end

    // new random fields at the falling edge over low registers so chains form
    task automatic drive_instr(input bit strobe);
        @(negedge clock);
        instr_valid  = strobe;
        instr_unit   = 2'($random(seed));
        instr_src_a  = 5'($random(seed) & 7);     // r0 one time in eight
        instr_src_b  = 5'($random(seed) & 7);
        instr_dest_a = 5'($random(seed) & 7);
        instr_dest_b = 5'($random(seed) & 7);
        instr_wr_a   = 1'($random(seed));
        instr_wr_b   = 1'($random(seed));
    endtask

    // slowest unit plus a full queue ahead for each instruction with 4x margin
    initial begin
        watchdog_cycles = 4 * (random_cycles + spaced_count) * (row_width + queue_depth) + 100;
        repeat (watchdog_cycles) @(posedge clock);
        $display("watchdog expired after %0d cycles, the run never finished", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clock        = 1'b0;
        reset        = 1'b0;
        instr_valid  = 1'b0;
        instr_unit   = '0;
        instr_src_a  = '0;
        instr_src_b  = '0;
        instr_dest_a = '0;
        instr_dest_b = '0;
        instr_wr_a   = 1'b0;
        instr_wr_b   = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        repeat (3) drive_instr(1'b0);   // idle outputs after reset

        // dense stretch every 40 cycles overflows the queue
        for (int i = 0; i < random_cycles; i++) begin
            drive_instr((i % 40) < 10 || ($random(seed) & 3) == 0);
        end

        // well spaced so every accepted one drains before the next
        for (int i = 0; i < spaced_count; i++) begin
            drive_instr(1'b1);
            repeat (row_width + 3) drive_instr(1'b0);
        end

        // wait for the last issues and writebacks
        drained = 1'b0;
        for (int i = 0; i < 4 * row_width * queue_depth && !drained; i++) begin
            @(negedge clock);
            drained = (issued_count == dut.u_chk.accepted_count) && (dut.u_chk.due_valid == '0);
        end
        if (!drained) begin
            tb_errors++;
            $display("accepted instructions did not drain after the last strobe");
        end
        if (issued_count != dut.u_chk.accepted_count) begin
            tb_errors++;
            $display("Mismatch issued_count: got 0x%0h expected 0x%0h",
                     issued_count, dut.u_chk.accepted_count);
        end

        $display("errors: checker %0d, testbench %0d (issued %0d, accepted %0d)",
                 dut.u_chk.error_count, tb_errors, issued_count, dut.u_chk.accepted_count);
        if (dut.u_chk.error_count == 0 && tb_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* flist.f */
issue_pkg.sv
instr_queue.sv
register_scoreboard.sv
hazard_issue_control.sv
writeback_sequencer.sv
issue_unit_top.sv
issue_unit_chk.sv
tb_issue_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the issue unit testbench with verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log
build_dir=obj_dir

if ! verilator --binary --assert --top-module tb_issue_unit \
        -f flist.f --Mdir "$build_dir" -o sim_issue_unit; then
    echo "verilator build failed"
    exit 1
fi

# keep running past the first assertion so the closing line is printed
if ! "./$build_dir/sim_issue_unit" +verilator+error+limit+1000 > "$log_file" 2>&1; then
    cat "$log_file"
    echo "simulation exited with an error status"
    exit 1
fi
cat "$log_file"

if grep -qx "Simulation passed" "$log_file"; then
    exit 0
fi
exit 1
